//--- source/prefetch_macros.svh
/*
 * Sizing macros for the instruction prefetch buffer
 * Buffer depth, word and address width, bytes per fetched word
 */

`ifndef PREFETCH_MACROS_SVH
`define PREFETCH_MACROS_SVH

// Words outstanding on the bus plus words held in the FIFO
`define PF_DEPTH 4

// Address and instruction word width
`define PF_WORD_W 32

// Bytes per fetched word
// Sets the address increment and the branch target alignment
`define PF_WORD_BYTES 4

`endif

//--- source/bus_pkg.sv
/*
 * Instruction bus types
 * Byte address and instruction word
 */

`include "prefetch_macros.svh"

package bus_pkg;

  // Byte address on the instruction bus
  // Requests always carry a word-aligned value
  typedef logic [`PF_WORD_W-1:0] addr_t;

  // Instruction word returned with a response
  typedef logic [`PF_WORD_W-1:0] word_t;

endpackage

//--- source/prefetch_pkg.sv
/*
 * Prefetch control types
 * Request state and occupancy count
 */

`include "prefetch_macros.svh"

package prefetch_pkg;

  // Request state
  // REQ_IDLE covers sequential prefetch and a fresh branch
  // REQ_BRANCH_WAIT replays a branch target the bus has not taken yet
  typedef enum logic {
    REQ_IDLE        = 1'b0,
    REQ_BRANCH_WAIT = 1'b1
  } pf_state_e;

  // Count from 0 to PF_DEPTH inclusive
  // Outstanding requests, pending flushes, FIFO occupancy
  typedef logic [$clog2(`PF_DEPTH):0] pf_cnt_t;

endpackage

//--- source/fetch_fifo.sv
/*
 * Instruction fetch FIFO
 * Circular buffer with occupancy count and one-cycle flush
 * Response bypass while empty
 */

`timescale 1ns/1ns

`include "prefetch_macros.svh"

module fetch_fifo (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  push_i,
  input  logic                  pop_i,
  input  logic                  flush_i,
  input  bus_pkg::word_t        wdata_i,
  output bus_pkg::word_t        rdata_o,
  output prefetch_pkg::pf_cnt_t cnt_o,
  output logic                  empty_o
);

  // Index into the entry array
  typedef logic [$clog2(`PF_DEPTH)-1:0] ptr_t;

  bus_pkg::word_t mem_q [`PF_DEPTH];

  ptr_t                  rptr_q;
  ptr_t                  wptr_q;
  ptr_t                  rptr_next;
  ptr_t                  wptr_next;
  prefetch_pkg::pf_cnt_t cnt_q;

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////

  assign empty_o = (cnt_q == '0);
  assign cnt_o   = cnt_q;

  // Bypass lets a response reach the core in its own cycle
  assign rdata_o = empty_o ? wdata_i : mem_q[rptr_q];

  // Pointer wrap, also correct for a depth that is not a power of two
  assign rptr_next = (rptr_q == ptr_t'(`PF_DEPTH - 1)) ? '0 : rptr_q + 1'b1;
  assign wptr_next = (wptr_q == ptr_t'(`PF_DEPTH - 1)) ? '0 : wptr_q + 1'b1;

  ////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rptr_q <= '0;
      wptr_q <= '0;
      cnt_q  <= '0;
    end else if (flush_i) begin
      // Flush wins over a push or pop in the same cycle
      rptr_q <= '0;
      wptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push_i) begin
        wptr_q <= wptr_next;
      end
      if (pop_i) begin
        rptr_q <= rptr_next;
      end
      if (push_i && !pop_i) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_i && !push_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (push_i && !flush_i) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

endmodule

//--- source/prefetch_controller.sv
/*
 * Prefetch request controller
 * Sequential and branch address generation with branch replay
 * Outstanding request and response flush counters
 * Fetch valid and FIFO push, pop and flush control
 */

`timescale 1ns/1ns

`include "prefetch_macros.svh"

module prefetch_controller (
  input  logic                  clk,
  input  logic                  rst_n,
  // Fetch side
  input  logic                  req_i,
  input  logic                  branch_i,
  input  bus_pkg::addr_t        branch_addr_i,
  output logic                  busy_o,
  input  logic                  fetch_ready_i,
  output logic                  fetch_valid_o,
  // Bus request and response
  output logic                  trans_valid_o,
  input  logic                  trans_ready_i,
  output bus_pkg::addr_t        trans_addr_o,
  input  logic                  resp_valid_i,
  // FIFO control and status
  output logic                  fifo_push_o,
  output logic                  fifo_pop_o,
  output logic                  fifo_flush_o,
  input  prefetch_pkg::pf_cnt_t fifo_cnt_i,
  input  logic                  fifo_empty_i
);

  prefetch_pkg::pf_state_e state_q;
  prefetch_pkg::pf_state_e next_state;

  // Requests accepted by the bus and not yet answered
  prefetch_pkg::pf_cnt_t cnt_q;
  prefetch_pkg::pf_cnt_t next_cnt;

  // Responses still to be dropped after a branch
  prefetch_pkg::pf_cnt_t flush_cnt_q;
  prefetch_pkg::pf_cnt_t next_flush_cnt;

  // FIFO count with the branch masking applied
  prefetch_pkg::pf_cnt_t fifo_cnt_masked;
  // One bit wider than a count so the sum cannot wrap
  logic [$clog2(`PF_DEPTH)+1:0] occupancy;

  bus_pkg::addr_t trans_addr_q;
  bus_pkg::addr_t word_mask;
  bus_pkg::addr_t aligned_branch_addr;
  bus_pkg::addr_t trans_addr_incr;

  logic trans_accept;
  logic discard;

  ////////////////////////////////////////
  // Status and fetch side
  ////////////////////////////////////////

  // Busy while a request is in flight or on offer
  assign busy_o = (cnt_q != '0) || trans_valid_o;

  // Responses that belong to the old path
  assign discard = branch_i || (flush_cnt_q != '0);

  // Word from the FIFO head or straight from the bus
  assign fetch_valid_o = (!fifo_empty_i || resp_valid_i) && !discard;

  ////////////////////////////////////////
  // Request generation
  ////////////////////////////////////////

  // Clears the byte offset within a word
  assign word_mask           = ~bus_pkg::addr_t'(`PF_WORD_BYTES - 1);
  assign aligned_branch_addr = branch_addr_i & word_mask;
  assign trans_addr_incr     = (trans_addr_q & word_mask) + bus_pkg::addr_t'(`PF_WORD_BYTES);

  // FIFO is flushed on a branch, so its words free up in that cycle
  assign fifo_cnt_masked = branch_i ? '0 : fifo_cnt_i;
  assign occupancy       = fifo_cnt_masked + cnt_q;

  // Issue only while every answer is sure to find room in the FIFO
  assign trans_valid_o = req_i && (occupancy < `PF_DEPTH);
  assign trans_accept  = trans_valid_o && trans_ready_i;

  // Address select and branch replay
  always_comb begin
    next_state   = state_q;
    trans_addr_o = trans_addr_q;
    case (state_q)
      prefetch_pkg::REQ_IDLE: begin
        if (branch_i) begin
          trans_addr_o = aligned_branch_addr;
        end else begin
          trans_addr_o = trans_addr_incr;
        end
        // Target not taken by the bus yet, keep offering it
        if (branch_i && !trans_accept) begin
          next_state = prefetch_pkg::REQ_BRANCH_WAIT;
        end
      end
      prefetch_pkg::REQ_BRANCH_WAIT: begin
        // A newer branch replaces the held target
        trans_addr_o = branch_i ? aligned_branch_addr : trans_addr_q;
        if (trans_accept) begin
          next_state = prefetch_pkg::REQ_IDLE;
        end
      end
      default: begin
        next_state = prefetch_pkg::REQ_IDLE;
      end
    endcase
  end

  ////////////////////////////////////////
  // FIFO control
  ////////////////////////////////////////

  // Buffer a response only if the core cannot take it directly
  assign fifo_push_o  = resp_valid_i && (!fifo_empty_i || !fetch_ready_i) && !discard;
  assign fifo_pop_o   = !fifo_empty_i && fetch_ready_i;
  assign fifo_flush_o = branch_i;

  // Outstanding requests
  always_comb begin
    next_cnt = cnt_q;
    if (trans_accept && !resp_valid_i) begin
      next_cnt = cnt_q + 1'b1;
    end else if (!trans_accept && resp_valid_i) begin
      next_cnt = cnt_q - 1'b1;
    end
  end

  // Responses to drop
  always_comb begin
    next_flush_cnt = flush_cnt_q;
    if (branch_i) begin
      // A response in the branch cycle is already dropped
      next_flush_cnt = cnt_q;
      if (resp_valid_i && (cnt_q != '0)) begin
        next_flush_cnt = cnt_q - 1'b1;
      end
    end else if (resp_valid_i && (flush_cnt_q != '0)) begin
      next_flush_cnt = flush_cnt_q - 1'b1;
    end
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= prefetch_pkg::REQ_IDLE;
      cnt_q        <= '0;
      flush_cnt_q  <= '0;
      // First sequential request then goes to the next word
      trans_addr_q <= '0;
    end else begin
      state_q     <= next_state;
      cnt_q       <= next_cnt;
      flush_cnt_q <= next_flush_cnt;
      if (branch_i || trans_accept) begin
        trans_addr_q <= trans_addr_o;
      end
    end
  end

endmodule

//--- source/prefetch_buffer.sv
/*
 * Instruction prefetch buffer top level
 * Request controller and fetch FIFO
 */

`timescale 1ns/1ns

`include "prefetch_macros.svh"

module prefetch_buffer (
  input  logic           clk,
  input  logic           rst_n,
  // Fetch side
  input  logic           req_i,
  input  logic           branch_i,
  input  bus_pkg::addr_t branch_addr_i,
  output logic           busy_o,
  output logic           fetch_valid_o,
  input  logic           fetch_ready_i,
  output bus_pkg::word_t fetch_rdata_o,
  // Bus request
  output logic           trans_valid_o,
  input  logic           trans_ready_i,
  output bus_pkg::addr_t trans_addr_o,
  // Bus response, always accepted
  input  logic           resp_valid_i,
  input  bus_pkg::word_t resp_rdata_i
);

  // Controller to FIFO
  logic                  fifo_push;
  logic                  fifo_pop;
  logic                  fifo_flush;
  // FIFO status back to the controller
  prefetch_pkg::pf_cnt_t fifo_cnt;
  logic                  fifo_empty;

  prefetch_controller prefetch_controller_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .busy_o        (busy_o),
    .fetch_ready_i (fetch_ready_i),
    .fetch_valid_o (fetch_valid_o),
    .trans_valid_o (trans_valid_o),
    .trans_ready_i (trans_ready_i),
    .trans_addr_o  (trans_addr_o),
    .resp_valid_i  (resp_valid_i),
    .fifo_push_o   (fifo_push),
    .fifo_pop_o    (fifo_pop),
    .fifo_flush_o  (fifo_flush),
    .fifo_cnt_i    (fifo_cnt),
    .fifo_empty_i  (fifo_empty)
  );

  // Response words pass through here to the core
  fetch_fifo fetch_fifo_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (fifo_push),
    .pop_i   (fifo_pop),
    .flush_i (fifo_flush),
    .wdata_i (resp_rdata_i),
    .rdata_o (fetch_rdata_o),
    .cnt_o   (fifo_cnt),
    .empty_o (fifo_empty)
  );

endmodule

//--- tests/tb_clock.sv
/*
 * Testbench clock generator
 * Free-running clock with a 40 ns period
 */

`timescale 1ns/1ns

module tb_clock (
  output logic clk_o
);

  // Half of the 40 ns period
  localparam int HALF_PERIOD = 20;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

endmodule

//--- tests/prefetch_buffer_chk.sv
/*
 * Bus and fetch protocol checks for the prefetch buffer
 * Waiting address hold, outstanding limit, no delivery on a branch
 * Bound to the top level
 */

`timescale 1ns/1ns

`include "prefetch_macros.svh"

module prefetch_buffer_chk (
  input logic           clk,
  input logic           rst_n,
  input logic           branch_i,
  input logic           trans_valid_i,
  input logic           trans_ready_i,
  input bus_pkg::addr_t trans_addr_i,
  input logic           resp_valid_i,
  input logic           fetch_valid_i
);

  // Wide enough that an overrun is visible
  logic [7:0] outstanding_q;
  // Count of failed assertions
  int         err_cnt = 0;

  // Requests accepted on the bus minus responses returned
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + 8'(trans_valid_i && trans_ready_i) - 8'(resp_valid_i);
    end
  end

  ////////////////////////////////////////
  // Properties
  ////////////////////////////////////////

  // A waiting request keeps its address unless a branch replaces it
  addr_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    trans_valid_i && !trans_ready_i && !branch_i |=> branch_i || $stable(trans_addr_i))
    else begin
      $error("trans_addr_o changed while a request waited for the bus");
      err_cnt++;
    end

  outstanding_limit_a: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding_q <= `PF_DEPTH)
    else begin
      $error("more than PF_DEPTH requests outstanding on the bus");
      err_cnt++;
    end

  // Old path words are never handed over in the branch cycle
  no_fetch_on_branch_a: assert property (@(posedge clk) disable iff (!rst_n)
    branch_i |-> !fetch_valid_i)
    else begin
      $error("fetch_valid_o high in a branch cycle");
      err_cnt++;
    end

endmodule

bind prefetch_buffer prefetch_buffer_chk prefetch_buffer_chk_i (
  .clk           (clk),
  .rst_n         (rst_n),
  .branch_i      (branch_i),
  .trans_valid_i (trans_valid_o),
  .trans_ready_i (trans_ready_i),
  .trans_addr_i  (trans_addr_o),
  .resp_valid_i  (resp_valid_i),
  .fetch_valid_i (fetch_valid_o)
);

//--- tests/prefetch_buffer_tb.sv
/*
 * Testbench top for the instruction prefetch buffer
 * In-order memory model with random ready and latency
 * Expected-address monitor and directed tests
 */

`timescale 1ns/1ns

`include "prefetch_macros.svh"

module prefetch_buffer_tb;

  localparam int DRIVE_DELAY    = 2;
  localparam int TIMEOUT_CYCLES = 200;

  logic           clk;
  logic           rst_n;
  logic           req_i;
  logic           branch_i;
  bus_pkg::addr_t branch_addr_i;
  logic           busy_o;
  logic           fetch_valid_o;
  logic           fetch_ready_i;
  bus_pkg::word_t fetch_rdata_o;
  logic           trans_valid_o;
  logic           trans_ready_i;
  bus_pkg::addr_t trans_addr_o;
  logic           resp_valid_i;
  bus_pkg::word_t resp_rdata_i;

  // Memory model state
  bus_pkg::addr_t req_addr_q [$];
  int             due_q [$];
  int             cycle_cnt = 0;
  int             last_due  = 0;
  int             accepted  = 0;
  logic [31:0]    rng_state = 32'h7871;
  bit             bus_stall = 1'b0;

  // Next address the core should see
  bus_pkg::addr_t exp_addr;
  int             delivered = 0;

  tb_clock tb_clock_i (
    .clk_o (clk)
  );

  prefetch_buffer prefetch_buffer_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .busy_o        (busy_o),
    .fetch_valid_o (fetch_valid_o),
    .fetch_ready_i (fetch_ready_i),
    .fetch_rdata_o (fetch_rdata_o),
    .trans_valid_o (trans_valid_o),
    .trans_ready_i (trans_ready_i),
    .trans_addr_o  (trans_addr_o),
    .resp_valid_i  (resp_valid_i),
    .resp_rdata_i  (resp_rdata_i)
  );

  function logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  ////////////////////////////////////////
  // Memory model and monitor
  ////////////////////////////////////////

  // Accept at the edge, answer in order 1 to 3 cycles later
  always @(posedge clk) begin
    int delay;
    cycle_cnt++;
    if (rst_n && trans_valid_o && trans_ready_i) begin
      delay = 1 + int'(next_random() % 3);
      last_due = (cycle_cnt + delay > last_due) ? cycle_cnt + delay : last_due + 1;
      req_addr_q.push_back(trans_addr_o);
      due_q.push_back(last_due);
      accepted++;
    end
    #DRIVE_DELAY;
    trans_ready_i = !bus_stall && ((next_random() % 4) != 0);
    if (req_addr_q.size() > 0 && due_q[0] <= cycle_cnt) begin
      resp_valid_i = 1'b1;
      resp_rdata_i = req_addr_q.pop_front() ^ 32'hA5A5_0000;
      void'(due_q.pop_front());
    end else begin
      resp_valid_i = 1'b0;
      resp_rdata_i = '0;
    end
  end

  // Every handed-over word must follow the expected path
  always @(posedge clk) begin
    if (rst_n && fetch_valid_o && fetch_ready_i) begin
      assert (fetch_rdata_o == (exp_addr ^ 32'hA5A5_0000))
        else stop_on_error($sformatf("fetch word %h, expected word for address %h",
                                     fetch_rdata_o, exp_addr));
      exp_addr = exp_addr + `PF_WORD_BYTES;
      delivered++;
    end
    // New path starts at the word holding the target
    if (branch_i) begin
      exp_addr = branch_addr_i - (branch_addr_i % `PF_WORD_BYTES);
    end
  end

  // Protocol properties of the bound checker
  always @(negedge clk) begin
    assert (prefetch_buffer_i.prefetch_buffer_chk_i.err_cnt == 0)
      else stop_on_error("a protocol assertion on the bus or fetch side failed");
  end

  ////////////////////////////////////////
  // Wait helpers
  ////////////////////////////////////////

  task automatic wait_for_deliveries(input int target);
    int waited;
    waited = 0;
    while (delivered < target) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        stop_on_error($sformatf("timed out waiting for fetch word number %0d", target));
      end
    end
  endtask

  // Drop the request and wait until nothing is in flight or buffered
  task automatic drain_to_idle();
    int waited;
    waited = 0;
    req_i = 1'b0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        stop_on_error("timed out waiting for the buffer to go idle");
      end
    end while (busy_o || fetch_valid_o || req_addr_q.size() != 0);
  endtask

  // Check the held target each cycle, the first cycle being the branch
  task automatic check_held_target(input bus_pkg::addr_t target, input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      assert (trans_addr_o == target)
        else stop_on_error($sformatf("trans_addr_o %h, expected held target %h",
                                     trans_addr_o, target));
      @(posedge clk);
      #DRIVE_DELAY;
      branch_i = 1'b0;
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic check_reset_and_sequential();
    @(negedge clk);
    assert (!trans_valid_o && !fetch_valid_o && !busy_o)
      else stop_on_error("trans_valid_o, fetch_valid_o or busy_o high after reset");
    @(posedge clk);
    #DRIVE_DELAY;
    req_i = 1'b1;
    fetch_ready_i = 1'b1;
    wait_for_deliveries(8);
  endtask

  task automatic check_branch_redirect();
    int waited;
    waited = 0;
    // Branch while old requests are still in flight
    do begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        stop_on_error("timed out waiting for outstanding requests");
      end
    end while (req_addr_q.size() < 2);
    @(posedge clk);
    #DRIVE_DELAY;
    branch_i = 1'b1;
    branch_addr_i = 32'h0000_1002;
    @(posedge clk);
    #DRIVE_DELAY;
    branch_i = 1'b0;
    wait_for_deliveries(delivered + 6);
  endtask

  task automatic check_branch_replay();
    int waited;
    bit taken;
    waited = 0;
    taken = 1'b0;
    @(posedge clk);
    bus_stall = 1'b1;
    #DRIVE_DELAY;
    branch_i = 1'b1;
    branch_addr_i = 32'h0000_2007;
    check_held_target(32'h0000_2004, 4);
    // Second branch during the wait replaces the target
    branch_i = 1'b1;
    branch_addr_i = 32'h0000_3001;
    check_held_target(32'h0000_3000, 4);
    @(posedge clk);
    bus_stall = 1'b0;
    while (!taken) begin
      @(negedge clk);
      assert (trans_addr_o == 32'h0000_3000)
        else stop_on_error($sformatf("trans_addr_o %h before target accepted", trans_addr_o));
      taken = trans_valid_o && trans_ready_i;
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        stop_on_error("timed out waiting for the branch target to be accepted");
      end
    end
    wait_for_deliveries(delivered + 4);
  endtask

  task automatic check_fetch_stall();
    int start_acc;
    int start_del;
    @(posedge clk);
    #DRIVE_DELAY;
    drain_to_idle();
    @(posedge clk);
    #DRIVE_DELAY;
    fetch_ready_i = 1'b0;
    req_i = 1'b1;
    start_acc = accepted;
    start_del = delivered;
    repeat (20) @(posedge clk);
    @(negedge clk);
    // Buffer full of held words and no further requests offered
    assert (accepted - start_acc == `PF_DEPTH && fetch_valid_o && !trans_valid_o)
      else stop_on_error($sformatf("%0d requests accepted during stall, fetch_valid_o %b, %s%b",
                                   accepted - start_acc, fetch_valid_o,
                                   "trans_valid_o ", trans_valid_o));
    @(posedge clk);
    #DRIVE_DELAY;
    fetch_ready_i = 1'b1;
    wait_for_deliveries(start_del + 2 * `PF_DEPTH);
  endtask

  task automatic check_idle();
    @(posedge clk);
    #DRIVE_DELAY;
    drain_to_idle();
    repeat (10) begin
      @(negedge clk);
      assert (!busy_o && !trans_valid_o)
        else stop_on_error("busy_o or trans_valid_o high with no request pending");
    end
  endtask

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////

  initial begin
    rst_n = 1'b0;
    req_i = 1'b0;
    branch_i = 1'b0;
    branch_addr_i = '0;
    fetch_ready_i = 1'b0;
    trans_ready_i = 1'b0;
    resp_valid_i = 1'b0;
    resp_rdata_i = '0;
    // Address register resets to 0, so fetching starts one word later
    exp_addr = 32'h0000_0004;
    repeat (4) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    check_reset_and_sequential();
    check_branch_redirect();
    check_branch_replay();
    check_fetch_stall();
    check_idle();
    @(negedge clk);
    if (prefetch_buffer_i.prefetch_buffer_chk_i.err_cnt != 0) begin
      stop_on_error("protocol assertions failed during the run");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

//--- prefetch.f
+incdir+source
source/bus_pkg.sv
source/prefetch_pkg.sv
source/fetch_fifo.sv
source/prefetch_controller.sv
source/prefetch_buffer.sv
tests/tb_clock.sv
tests/prefetch_buffer_chk.sv
tests/prefetch_buffer_tb.sv
